// File: verilog/uart_pkg.sv
// constants shared by the four-channel uart hub
// clock, baud and divider values plus channel count, taken by scoped name
package uart_pkg;

  // system clock and line rate
  localparam logic [31:0] CLK_FREQ = 32'd25_000_000; // 40 ns period
  localparam logic [31:0] BAUD     = 32'd1_562_500;

  // dividers
  localparam int unsigned TX_DIV = CLK_FREQ / BAUD; // clocks per bit, 16
  localparam int unsigned RX_DIV = TX_DIV / 2;      // clocks per half bit, 8

  // bit-rate counter widths and wrap values
  localparam int unsigned TX_CNT_W = $clog2(TX_DIV);
  localparam int unsigned RX_CNT_W = $clog2(RX_DIV);
  localparam logic [TX_CNT_W-1:0] TX_TOP = TX_CNT_W'(TX_DIV - 1);
  localparam logic [RX_CNT_W-1:0] RX_TOP = RX_CNT_W'(RX_DIV - 1);

  // channels
  localparam int unsigned N_CHAN = 4;
  localparam int unsigned CHAN_W = $clog2(N_CHAN); // tag width, 2

  // frame: start + 8 data + stop, no parity
  localparam int unsigned FRAME_BITS = 10;

  // receiver state once the byte is held
  // half-bit ticks 0..17 cover start and data, 18 lands early in stop
  localparam logic [4:0] RX_DONE = 5'(2 * (FRAME_BITS - 1));

endpackage

// File: verilog/chan_if.sv
`timescale 1ns/1ps
// one channel's link between dispatcher/collector and its tx/rx pair
// the hub builds one instance per channel
interface chan_if;

  logic       wr;       // one-cycle write strobe
  logic [7:0] tx_data;  // byte to send, valid with wr
  logic       busy;     // frame on the line
  logic       rx_valid; // received byte held
  logic [7:0] rx_data;
  logic       rd;       // one-cycle read strobe, frees the holding reg

  // host write side
  modport disp (
    output wr,
    output tx_data,
    input  busy
  );

  modport tx (
    input  wr,
    input  tx_data,
    output busy
  );

  // host read side
  modport coll (
    output rd,
    input  rx_valid,
    input  rx_data
  );

  modport rx (
    input  rd,
    output rx_valid,
    output rx_data
  );

endinterface

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
// serial transmitter, 8N1, lsb first
// a wr strobe while idle starts a frame; busy covers the whole frame
module uart_tx (
  input  logic clk,
  input  logic resetq,
  chan_if.tx   ch,
  output logic line
);

  logic [3:0]                    bitcount; // 0 = idle, else bits still to finish
  logic [8:0]                    shifter;  // stop bit over the data byte
  logic [uart_pkg::TX_CNT_W-1:0] cnt;      // bit-rate counter
  logic                          tick;     // end of one bit time
  logic                          sending;
  logic                          start;    // accepted write

  assign sending = |bitcount;
  assign ch.busy = sending;
  assign tick    = (cnt == uart_pkg::TX_TOP);
  assign start   = ch.wr && !sending;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      bitcount <= '0;
      cnt      <= '0;
      line     <= 1'b1; // idle high
    end else if (start) begin
      bitcount <= 4'(uart_pkg::FRAME_BITS);
      cnt      <= '0;   // full-length start bit
      line     <= 1'b0; // start bit next cycle
    end else if (sending) begin
      cnt <= tick ? '0 : cnt + 1'b1;
      if (tick) begin
        line     <= shifter[0];
        bitcount <= bitcount - 4'd1;
      end
    end
  end

  // data bits go out lsb first, then the stop bit
  // ones shift in behind so the line rests high afterwards
  always_ff @(posedge clk) begin
    if (start) begin
      shifter <= {1'b1, ch.tx_data};
    end else if (sending && tick) begin
      shifter <= {1'b1, shifter[8:1]};
    end
  end

  // the dispatcher waits for busy to drop before the next write
  a_no_wr_busy : assert property (
    @(posedge clk) disable iff (!resetq)
    ch.wr |-> !ch.busy
  );

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
// serial receiver, 8N1, lsb first, mid-bit sampling off a half-bit tick
// the byte is held with rx_valid until a rd strobe; frames arriving meanwhile are lost
module uart_rx (
  input  logic clk,
  input  logic resetq,
  input  logic line,
  chan_if.rx   ch
);

  // bitcount: all ones idle, 0..17 half-bit steps, RX_DONE byte held
  logic [4:0]                    bitcount;
  logic [4:0]                    bitcount_n;
  logic [7:0]                    shifter;
  logic [2:0]                    hh;       // line history, newest in bit 0
  logic [uart_pkg::RX_CNT_W-1:0] cnt;      // half-bit counter
  logic                          idle;
  logic                          tick;
  logic                          startbit;
  logic                          sample;

  assign idle        = &bitcount;
  assign ch.rx_valid = (bitcount == uart_pkg::RX_DONE);
  assign ch.rx_data  = shifter;
  assign tick        = (cnt == uart_pkg::RX_TOP);

  // high then two lows, a one-cycle glitch is ignored
  assign startbit = idle && (hh == 3'b100);

  // ticks 3, 5 .. 17 after the edge sit mid-bit on data 0..7
  assign sample = tick && !bitcount[0] && (bitcount >= 5'd2) && (bitcount <= 5'd16);

  always_comb begin
    if (startbit) begin
      bitcount_n = '0;
    end else if (!idle && !ch.rx_valid && tick) begin
      bitcount_n = bitcount + 5'd1; // next half bit
    end else if (ch.rx_valid && ch.rd) begin
      bitcount_n = '1;              // back to idle
    end else begin
      bitcount_n = bitcount;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      hh       <= 3'b111; // line assumed idle
      bitcount <= '1;
      cnt      <= '0;
    end else begin
      hh       <= {hh[1:0], line};
      bitcount <= bitcount_n;
      cnt      <= (startbit || tick) ? '0 : cnt + 1'b1; // restarts on the edge
    end
  end

  // hh[1] is the line two cycles back
  // the counter restarts a cycle after the edge shows there, so the delays cancel
  always_ff @(posedge clk) begin
    if (sample) begin
      shifter <= {hh[1], shifter[7:1]};
    end
  end

  // collector only reads a channel it saw valid
  a_rd_valid : assert property (
    @(posedge clk) disable iff (!resetq)
    ch.rd |-> ch.rx_valid
  );

endmodule

// File: verilog/tx_dispatch.sv
`timescale 1ns/1ps
// host write port with a four-phase req/ack, each byte tagged with its channel
// latches the byte, waits for that transmitter to go idle, strobes its wr once
module tx_dispatch (
  input  logic                        clk,
  input  logic                        resetq,
  input  logic                        wr_req,
  input  logic [uart_pkg::CHAN_W-1:0] wr_chan,
  input  logic [7:0]                  wr_data,
  output logic                        wr_ack,
  chan_if.disp                        ch [uart_pkg::N_CHAN]
);

  logic                        wait_q; // byte latched while target may be busy
  logic                        ack_q;  // ack held until req drops
  logic [uart_pkg::CHAN_W-1:0] sel_q;  // target channel
  logic [7:0]                  data_q;
  logic [uart_pkg::N_CHAN-1:0] busy_v;
  logic [uart_pkg::N_CHAN-1:0] wr_v;   // one-hot write strobe
  logic                        take;   // new request accepted
  logic                        fire;   // hand-off cycle

  assign take   = wr_req && !wait_q && !ack_q;
  assign fire   = wait_q && !busy_v[sel_q];
  assign wr_v   = {{(uart_pkg::N_CHAN - 1){1'b0}}, fire} << sel_q;
  assign wr_ack = ack_q;

  for (genvar i = 0; i < uart_pkg::N_CHAN; i++) begin : g_chan
    assign busy_v[i]     = ch[i].busy;
    assign ch[i].wr      = wr_v[i];
    assign ch[i].tx_data = data_q; // only the strobed channel takes it
  end

  // idle -> wait -> ack -> idle
  always_ff @(posedge clk) begin
    if (!resetq) begin
      wait_q <= 1'b0;
      ack_q  <= 1'b0;
    end else if (take) begin
      wait_q <= 1'b1;
    end else if (fire) begin
      wait_q <= 1'b0;
      ack_q  <= 1'b1;
    end else if (ack_q && !wr_req) begin
      ack_q  <= 1'b0; // drops one cycle after req low
    end
  end

  // chan and data sampled once as the request is taken
  always_ff @(posedge clk) begin
    if (take) begin
      sel_q  <= wr_chan;
      data_q <= wr_data;
    end
  end

  // host lowers req only once the byte is acked
  a_req_held : assert property (
    @(posedge clk) disable iff (!resetq)
    $fell(wr_req) |-> wr_ack
  );

endmodule

// File: verilog/rx_collect.sv
`timescale 1ns/1ps
// host read port draining the receivers round-robin
// offers each byte with its channel tag over a four-phase req/ack
module rx_collect (
  input  logic                        clk,
  input  logic                        resetq,
  output logic                        rd_req,
  output logic [uart_pkg::CHAN_W-1:0] rd_chan,
  output logic [7:0]                  rd_data,
  input  logic                        rd_ack,
  chan_if.coll                        ch [uart_pkg::N_CHAN]
);

  logic                        offer_q; // byte on offer drives rd_req
  logic                        drain_q; // waiting for ack low
  logic [uart_pkg::CHAN_W-1:0] last_q;  // last channel served
  logic [uart_pkg::CHAN_W-1:0] pick;
  logic [uart_pkg::CHAN_W-1:0] idx;
  logic                        found;
  logic                        take;    // latch and strobe rd this cycle
  logic [uart_pkg::N_CHAN-1:0] valid_v;
  logic [uart_pkg::N_CHAN-1:0] rd_v;
  logic [7:0]                  rx_d [uart_pkg::N_CHAN];

  for (genvar i = 0; i < uart_pkg::N_CHAN; i++) begin : g_chan
    assign valid_v[i] = ch[i].rx_valid;
    assign rx_d[i]    = ch[i].rx_data;
    assign ch[i].rd   = rd_v[i];
  end

  // search starts just past the last channel served
  always_comb begin
    found = 1'b0;
    pick  = last_q;
    idx   = last_q;
    for (int k = 1; k <= uart_pkg::N_CHAN; k++) begin
      idx = last_q + k[uart_pkg::CHAN_W-1:0]; // wraps since N_CHAN is a power of two
      if (!found && valid_v[idx]) begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  assign take   = found && !offer_q && !drain_q;
  assign rd_v   = {{(uart_pkg::N_CHAN - 1){1'b0}}, take} << pick; // frees that receiver
  assign rd_req = offer_q;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      offer_q <= 1'b0;
      drain_q <= 1'b0;
      last_q  <= '1; // channel 0 first
    end else if (take) begin
      offer_q <= 1'b1;
      last_q  <= pick;
    end else if (offer_q && rd_ack) begin
      offer_q <= 1'b0;
      drain_q <= 1'b1;
    end else if (drain_q && !rd_ack) begin
      drain_q <= 1'b0;
    end
  end

  // offered byte and tag
  always_ff @(posedge clk) begin
    if (take) begin
      rd_chan <= pick;
      rd_data <= rx_d[pick];
    end
  end

  // host acks only an offer that is up
  a_ack_on_offer : assert property (
    @(posedge clk) disable iff (!resetq)
    $rose(rd_ack) |-> rd_req
  );

endmodule

// File: verilog/uart_hub.sv
`timescale 1ns/1ps
// four-channel uart hub, top level
// host writes tagged bytes in, received bytes come back tagged on the read port
module uart_hub (
  input  logic                        clk,
  input  logic                        resetq,
  // host write port
  input  logic                        wr_req,
  input  logic [uart_pkg::CHAN_W-1:0] wr_chan,
  input  logic [7:0]                  wr_data,
  output logic                        wr_ack,
  // host read port
  output logic                        rd_req,
  output logic [uart_pkg::CHAN_W-1:0] rd_chan,
  output logic [7:0]                  rd_data,
  input  logic                        rd_ack,
  // serial lines
  input  logic [uart_pkg::N_CHAN-1:0] rx,
  output logic [uart_pkg::N_CHAN-1:0] tx
);

  chan_if ch [uart_pkg::N_CHAN] (); // one link per channel

  tx_dispatch u_disp (
    .clk     (clk),
    .resetq  (resetq),
    .wr_req  (wr_req),
    .wr_chan (wr_chan),
    .wr_data (wr_data),
    .wr_ack  (wr_ack),
    .ch      (ch)
  );

  for (genvar i = 0; i < uart_pkg::N_CHAN; i++) begin : g_chan
    uart_tx u_tx (
      .clk    (clk),
      .resetq (resetq),
      .ch     (ch[i]),
      .line   (tx[i])
    );

    uart_rx u_rx (
      .clk    (clk),
      .resetq (resetq),
      .line   (rx[i]),
      .ch     (ch[i])
    );
  end

  rx_collect u_coll (
    .clk     (clk),
    .resetq  (resetq),
    .rd_req  (rd_req),
    .rd_chan (rd_chan),
    .rd_data (rd_data),
    .rd_ack  (rd_ack),
    .ch      (ch)
  );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
// clock and reset for the hub testbench
// 40 ns clock, resetq held low for the first 4 rising edges
module tb_clock (
  output logic clk,
  output logic resetq
);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk; // half of the 40 ns period
    end
  end

  initial begin
    resetq = 1'b0;
    repeat (4) @(posedge clk);
    #2 resetq = 1'b1; // released with the other stimulus, 2 ns after the edge
  end

endmodule

// File: testbench/tb_uart_hub.sv
`timescale 1ns/1ps
// uart hub testbench with tx of channel i looped back to rx of channel i+1
// host writes use the write handshake
// a reader process acks and scores every offer
module tb_uart_hub;

  logic                        clk;
  logic                        resetq;
  logic                        wr_req;
  logic [uart_pkg::CHAN_W-1:0] wr_chan;
  logic [7:0]                  wr_data;
  logic                        wr_ack;
  logic                        rd_req;
  logic [uart_pkg::CHAN_W-1:0] rd_chan;
  logic [7:0]                  rd_data;
  logic                        rd_ack;
  logic [uart_pkg::N_CHAN-1:0] rx;
  logic [uart_pkg::N_CHAN-1:0] tx;

  logic [uart_pkg::CHAN_W-1:0] exp_chan [$]; // scoreboard of channels the bytes return on
  logic [7:0]                  exp_data [$];
  logic [15:0]                 lfsr;
  int                          err_count;
  int                          errs_at_start;
  int                          tests_passed;
  int                          tests_failed;
  string                       cur_test;

  tb_clock u_clk (
    .clk    (clk),
    .resetq (resetq)
  );

  uart_hub u_dut (
    .clk     (clk),
    .resetq  (resetq),
    .wr_req  (wr_req),
    .wr_chan (wr_chan),
    .wr_data (wr_data),
    .wr_ack  (wr_ack),
    .rd_req  (rd_req),
    .rd_chan (rd_chan),
    .rd_data (rd_data),
    .rd_ack  (rd_ack),
    .rx      (rx),
    .tx      (tx)
  );

  // loopback ring
  for (genvar i = 0; i < uart_pkg::N_CHAN; i++) begin : g_loop
    assign rx[(i + 1) % uart_pkg::N_CHAN] = tx[i];
  end

  // expected receive channel for a byte written to chan
  // the data byte itself comes back unchanged
  function automatic logic [uart_pkg::CHAN_W-1:0] loop_chan(
    input logic [uart_pkg::CHAN_W-1:0] chan
  );
    int c;
    c = (int'(chan) + 1) % int'(uart_pkg::N_CHAN);
    loop_chan = c[uart_pkg::CHAN_W-1:0];
  endfunction

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    lfsr_step = {s[14:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  function automatic int count_pending(input logic [uart_pkg::CHAN_W-1:0] chan);
    int n;
    n = 0;
    foreach (exp_chan[k]) begin
      if (exp_chan[k] == chan) n++;
    end
    count_pending = n;
  endfunction

  // sample and drive 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    errs_at_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d errors", cur_test, err_count - errs_at_start);
    end
  endtask

  // full four-phase write
  // lat counts edges from req up to ack seen
  task automatic host_write(
    input  logic [uart_pkg::CHAN_W-1:0] chan,
    input  logic [7:0]                  data,
    output int                          lat
  );
    int n;
    exp_chan.push_back(loop_chan(chan));
    exp_data.push_back(data);
    wr_chan = chan;
    wr_data = data;
    wr_req  = 1'b1;
    lat     = 0;
    while (!wr_ack && lat < 1000) begin
      step();
      lat++;
    end
    if (!wr_ack) begin
      err_count++;
      $display("error in %s: no wr_ack for a write to channel %0d", cur_test, chan);
    end
    wr_req = 1'b0;
    n      = 0;
    while (wr_ack && n < 20) begin
      step();
      n++;
    end
    if (wr_ack) begin
      err_count++;
      $display("error in %s: wr_ack stuck high after wr_req dropped", cur_test);
    end
  endtask

  // a channel's previous byte has to be read before it is used again
  task automatic wait_free(input logic [uart_pkg::CHAN_W-1:0] chan);
    int n;
    n = 0;
    while (count_pending(chan) != 0 && n < 2000) begin
      step();
      n++;
    end
    if (count_pending(chan) != 0) begin
      err_count++;
      $display("error in %s: byte due on channel %0d never read back", cur_test, chan);
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (exp_chan.size() != 0 && n < limit) begin
      step();
      n++;
    end
    if (exp_chan.size() != 0) begin
      err_count++;
      $display("error in %s: %0d bytes never came back", cur_test, exp_chan.size());
    end
  endtask

  // score one offer against the first entry on its channel
  // which keeps per-channel order
  task automatic check_offer();
    int hit;
    hit = -1;
    foreach (exp_chan[k]) begin
      if (hit < 0 && exp_chan[k] == rd_chan) hit = k;
    end
    if (hit < 0) begin
      err_count++;
      $display("error in %s: byte %h offered on channel %0d, none expected there",
               cur_test, rd_data, rd_chan);
    end else begin
      if (exp_data[hit] !== rd_data) begin
        err_count++;
        $display("[FAIL] %s chan %0d: expected %h, actual %h",
                 cur_test, rd_chan, exp_data[hit], rd_data);
      end
      exp_chan.delete(hit);
      exp_data.delete(hit);
    end
  endtask

  // read side acking each offer promptly
  initial begin : reader
    int hold;
    rd_ack = 1'b0;
    hold   = 0;
    forever begin
      step();
      if (!rd_ack) begin
        if (resetq && rd_req) begin
          check_offer();
          rd_ack = 1'b1;
          hold   = 0;
        end
      end else if (!rd_req) begin
        rd_ack = 1'b0; // completes the four phases
      end else begin
        hold++;
        if (hold == 50) begin
          err_count++;
          $display("error in %s: rd_req still high 50 cycles after rd_ack", cur_test);
        end
      end
    end
  end

  initial begin : main
    int                          n;
    int                          lat;
    int                          lat2;
    int                          frame;
    logic [7:0]                  v;
    logic [7:0]                  d;
    logic [uart_pkg::CHAN_W-1:0] c;
    wr_req       = 1'b0;
    wr_chan      = '0;
    wr_data      = '0;
    lfsr         = 16'd44431;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_test     = "reset";
    frame        = int'(uart_pkg::FRAME_BITS * uart_pkg::TX_DIV); // 160 clocks

    n = 0;
    do begin
      step();
      n++;
    end while (!resetq && n < 20);
    if (!resetq) begin
      err_count++;
      $display("error: reset never released");
    end

    begin_test("reset_idle");
    for (n = 0; n < 100; n++) begin
      step();
      if (tx !== {uart_pkg::N_CHAN{1'b1}}) begin
        err_count++;
        $display("[FAIL] %s tx: expected %h, actual %h",
                 cur_test, {uart_pkg::N_CHAN{1'b1}}, tx);
      end
      if (wr_ack !== 1'b0) begin
        err_count++;
        $display("[FAIL] %s wr_ack: expected 0, actual %b", cur_test, wr_ack);
      end
      if (rd_req !== 1'b0) begin
        err_count++;
        $display("[FAIL] %s rd_req: expected 0, actual %b", cur_test, rd_req);
      end
    end
    end_test();

    begin_test("single_byte");
    host_write(2'd0, 8'h5A, lat);
    if (lat != 2) begin // idle channel
      err_count++;
      $display("[FAIL] %s ack latency: expected 2, actual %0d", cur_test, lat);
    end
    wait_drained(2000);
    end_test();

    begin_test("all_channels");
    for (n = 0; n < int'(uart_pkg::N_CHAN); n++) begin
      c = n[uart_pkg::CHAN_W-1:0];
      d = {n[3:0], ~n[3:0]};
      host_write(c, d, lat);
    end
    wait_drained(3000);
    end_test();

    begin_test("back_to_back");
    host_write(2'd2, 8'hC3, lat);
    host_write(2'd2, 8'h81, lat2); // waits out the first frame
    if (lat2 < frame - 8 || lat2 > frame + 8) begin
      err_count++;
      $display("[FAIL] %s second ack latency: expected about %0d, actual %0d",
               cur_test, frame, lat2);
    end
    wait_drained(3000);
    end_test();

    begin_test("random_traffic");
    for (n = 0; n < 20; n++) begin
      take_bits(2, v);
      c = v[uart_pkg::CHAN_W-1:0];
      take_bits(8, d);
      wait_free(loop_chan(c));
      host_write(c, d, lat);
    end
    wait_drained(3000);
    if (exp_chan.size() != 0) begin
      err_count++;
      $display("[FAIL] %s scoreboard size: expected 0, actual %0d", cur_test, exp_chan.size());
    end
    end_test();

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
verilog/uart_pkg.sv
verilog/chan_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/tx_dispatch.sv
verilog/rx_collect.sv
verilog/uart_hub.sv
testbench/tb_clock.sv
testbench/tb_uart_hub.sv

// File: run_sim.sh
#!/bin/sh
# build the hub testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_uart_hub -f all.f -o tb_uart_hub \
  && ./obj_dir/tb_uart_hub > sim.log 2>&1 \
  || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log \
  && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }
